/* verilog/board_pkg.sv */
`default_nettype none

package board_pkg;

    // Player slots on the board and how many have keyboard controls
    localparam int NUM_PLAYERS = 4;
    localparam int KEY_PLAYERS = 3;

    // One player's controls, up sits at bit 0
    typedef struct packed {
        logic [5:0] buttons;
        logic       right;
        logic       left;
        logic       down;
        logic       up;
    } joy_t;

    // Board joystick word as delivered by the framework, active low
    typedef struct packed {
        logic [3:0] unused;
        logic       coin;
        logic       start;
        joy_t       joy;
    } board_joy_t;

    // Merged raw controls, active high
    typedef struct packed {
        logic coin;
        logic start;
        joy_t joy;
    } player_in_t;

    // Rotated, masked and at game polarity
    typedef struct packed {
        logic coin;
        logic start;
        joy_t joy;
    } player_out_t;

    // Settings word from the OSD, bit 0 at the bottom
    typedef struct packed {
        logic [20:0] spare_hi;
        logic        wide;
        logic        psg_off;
        logic        fm_off;
        logic [1:0]  fxlevel;
        logic        pause;
        logic        test;
        logic        flip;
        logic [1:0]  rotate;
        logic        spare_lo;
    } settings_t;

endpackage

`default_nettype wire

/* verilog/board_reset.sv */
`default_nettype none

module board_reset #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic sys_rst_n,
    output logic game_rst_n
);

    localparam int CNT_W = $clog2(RST_CYCLES + 1);

    logic [CNT_W-1:0] sys_cnt;
    logic [CNT_W-1:0] game_cnt;
    logic             flip_last;
    logic             sys_cause;
    logic             game_cause;

    assign sys_cause  = !rst_n || !pll_locked || rst_req;
    // The game reset also covers every system reset cycle
    assign game_cause = sys_cause || !sys_rst_n || downloading || soft_rst ||
                        (dip_flip != flip_last);

    // Flip setting history, for change detection
    always_ff @(posedge clk_sys) begin
        flip_last <= dip_flip;
    end

    always_ff @(posedge clk_sys) begin
        if (sys_cause) begin
            sys_cnt   <= CNT_W'(RST_CYCLES);
            sys_rst_n <= 1'b0;
        end else begin
            if (sys_cnt != '0) begin
                sys_cnt <= sys_cnt - 1'b1;
            end
            // Release on the last count
            sys_rst_n <= (sys_cnt <= CNT_W'(1));
        end
    end

    always_ff @(posedge clk_sys) begin
        if (game_cause) begin
            game_cnt   <= CNT_W'(RST_CYCLES);
            game_rst_n <= 1'b0;
        end else begin
            if (game_cnt != '0) begin
                game_cnt <= game_cnt - 1'b1;
            end
            game_rst_n <= (game_cnt <= CNT_W'(1));
        end
    end

endmodule

`default_nettype wire

/* verilog/input_merge.sv */
`default_nettype none

module input_merge
    import board_pkg::*;
(
    input  logic                         clk_sys,
    input  logic                         rst_n,
    input  board_joy_t [NUM_PLAYERS-1:0] board_joy,
    input  joy_t       [KEY_PLAYERS-1:0] key_joy,
    input  logic       [NUM_PLAYERS-1:0] key_start,
    input  logic       [NUM_PLAYERS-1:0] key_coin,
    output player_in_t [NUM_PLAYERS-1:0] raw
);

    // Keyboard directions and buttons lined up per player slot
    joy_t [NUM_PLAYERS-1:0] key_dir;

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_key
        if (p < KEY_PLAYERS) begin : g_mapped
            assign key_dir[p] = key_joy[p];
        end else begin : g_none
            // No keyboard layout for this player
            assign key_dir[p] = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            raw <= '0;
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                // Board joysticks are active low, keys active high
                raw[p].joy   <= ~board_joy[p].joy | key_dir[p];
                raw[p].start <= ~board_joy[p].start | key_start[p];
                raw[p].coin  <= ~board_joy[p].coin | key_coin[p];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/player_map.sv */
`default_nettype none

module player_map
    import board_pkg::*;
#(
    parameter int BUTTONS    = 2,
    parameter int ACTIVE_LOW = 1
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  player_in_t  raw,
    input  logic        rot_control,
    output player_out_t mapped
);

    // Live buttons, the rest read as released
    localparam logic [5:0]  BTN_MASK = 6'((1 << BUTTONS) - 1);
    localparam logic [11:0] POL_MASK = (ACTIVE_LOW != 0) ? 12'hfff : 12'h000;

    player_in_t rot_word;

    always_comb begin
        rot_word = raw;
        if (rot_control) begin
            // Quarter turn clockwise for a rotated screen
            rot_word.joy.up    = raw.joy.left;
            rot_word.joy.right = raw.joy.up;
            rot_word.joy.down  = raw.joy.right;
            rot_word.joy.left  = raw.joy.down;
        end
        rot_word.joy.buttons = raw.joy.buttons & BTN_MASK;
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            // Inactive at game polarity
            mapped <= player_out_t'(POL_MASK);
        end else begin
            mapped <= player_out_t'(rot_word ^ POL_MASK);
        end
    end

endmodule

`default_nettype wire

/* verilog/input_collect.sv */
`default_nettype none

module input_collect
    import board_pkg::*;
#(
    parameter int ACTIVE_LOW = 1
) (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  player_out_t [NUM_PLAYERS-1:0] mapped,
    input  logic                          key_pause,
    input  logic                          key_reset,
    input  logic                          key_service,
    input  logic                          osd_shown,
    output joy_t        [NUM_PLAYERS-1:0] game_joy,
    output logic        [NUM_PLAYERS-1:0] game_start,
    output logic        [NUM_PLAYERS-1:0] game_coin,
    output logic                          game_service,
    output logic                          game_pause,
    output logic                          soft_rst
);

    localparam logic POL = (ACTIVE_LOW != 0);

    logic pause_last;
    logic reset_last;

    // Player fields gathered into the game vectors
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            game_joy     <= {(NUM_PLAYERS * $bits(joy_t)){POL}};
            game_start   <= {NUM_PLAYERS{POL}};
            game_coin    <= {NUM_PLAYERS{POL}};
            game_service <= POL;
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                game_joy[p]   <= mapped[p].joy;
                game_start[p] <= mapped[p].start;
                game_coin[p]  <= mapped[p].coin;
            end
            game_service <= key_service ^ POL;
        end
    end

    // Pause toggle and soft reset pulse
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            pause_last <= 1'b0;
            reset_last <= 1'b0;
            game_pause <= 1'b0;
            soft_rst   <= 1'b0;
        end else begin
            pause_last <= key_pause;
            reset_last <= key_reset;
            // Keys go to the menu while it is open
            if (key_pause && !pause_last && !osd_shown) begin
                game_pause <= ~game_pause;
            end
            soft_rst <= key_reset & ~reset_last & ~osd_shown;
        end
    end

endmodule

`default_nettype wire

/* verilog/dip_decode.sv */
`default_nettype none

module dip_decode
    import board_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  settings_t   status,
    input  logic        core_vertical,
    input  logic        game_pause,
    input  logic        key_test,
    output logic [1:0]  rotate,
    output logic        rot_control,
    output logic        dip_flip,
    output logic        dip_test,
    output logic        dip_pause,
    output logic        enable_fm,
    output logic        enable_psg,
    output logic [1:0]  dip_fxlevel,
    output logic [11:0] hdmi_arx,
    output logic [11:0] hdmi_ary
);

    localparam logic [11:0] AR_STD_X  = 12'd4;
    localparam logic [11:0] AR_STD_Y  = 12'd3;
    localparam logic [11:0] AR_WIDE_X = 12'd16;
    localparam logic [11:0] AR_WIDE_Y = 12'd9;

    logic        rot_next;
    logic [11:0] ar_x;
    logic [11:0] ar_y;

    // Joystick remap only makes sense on a vertical game
    assign rot_next = status.rotate[0] & core_vertical;
    assign ar_x     = status.wide ? AR_WIDE_X : AR_STD_X;
    assign ar_y     = status.wide ? AR_WIDE_Y : AR_STD_Y;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            rotate      <= 2'b00;
            rot_control <= 1'b0;
            dip_flip    <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            dip_fxlevel <= 2'b00;
        end else begin
            rotate      <= status.rotate;
            rot_control <= rot_next;
            dip_flip    <= status.flip;
            dip_test    <= status.test | key_test;
            dip_pause   <= status.pause | game_pause;
            enable_fm   <= ~status.fm_off;
            enable_psg  <= ~status.psg_off;
            dip_fxlevel <= status.fxlevel;
        end
    end

    // Unrotated vertical game stands on its side
    always_ff @(posedge clk_sys) begin
        if (core_vertical && !rot_next) begin
            hdmi_arx <= ar_y;
            hdmi_ary <= ar_x;
        end else begin
            hdmi_arx <= ar_x;
            hdmi_ary <= ar_y;
        end
    end

endmodule

`default_nettype wire

/* verilog/status_led.sv */
`default_nettype none

module status_led #(
    parameter int BLINK_HALF = 1024
) (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int CNT_W = $clog2(BLINK_HALF + 1);

    logic [CNT_W-1:0] blink_cnt;
    logic             blink;

    // Free running blink for the download indication
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            blink_cnt <= '0;
            blink     <= 1'b0;
        end else if (blink_cnt == CNT_W'(BLINK_HALF - 1)) begin
            blink_cnt <= '0;
            blink     <= ~blink;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            led <= 1'b0;
        end else begin
            led <= downloading ? blink : (osd_shown | game_led[0]);
        end
    end

endmodule

`default_nettype wire

/* verilog/board_top.sv */
`default_nettype none

module board_top
    import board_pkg::*;
#(
    parameter int BUTTONS    = 2,
    parameter int ACTIVE_LOW = 1,
    parameter int RST_CYCLES = 16,
    parameter int BLINK_HALF = 1024
) (
    input  logic                         clk_sys,
    input  logic                         rst_n,
    input  logic                         pll_locked,
    input  logic                         rst_req,
    input  logic                         downloading,
    // Board and keyboard controls
    input  board_joy_t [NUM_PLAYERS-1:0] board_joy,
    input  joy_t       [KEY_PLAYERS-1:0] key_joy,
    input  logic       [NUM_PLAYERS-1:0] key_start,
    input  logic       [NUM_PLAYERS-1:0] key_coin,
    input  logic                         key_pause,
    input  logic                         key_reset,
    input  logic                         key_test,
    input  logic                         key_service,
    // Settings
    input  settings_t                    status,
    input  logic       [6:0]             core_mod,
    input  logic                         osd_shown,
    input  logic       [1:0]             game_led,
    // Resets
    output logic                         sys_rst_n,
    output logic                         game_rst_n,
    // Game side controls
    output joy_t       [NUM_PLAYERS-1:0] game_joy,
    output logic       [NUM_PLAYERS-1:0] game_start,
    output logic       [NUM_PLAYERS-1:0] game_coin,
    output logic                         game_service,
    // Switches
    output logic       [1:0]             rotate,
    output logic                         dip_flip,
    output logic                         dip_test,
    output logic                         dip_pause,
    output logic                         enable_fm,
    output logic                         enable_psg,
    output logic       [1:0]             dip_fxlevel,
    output logic       [11:0]            hdmi_arx,
    output logic       [11:0]            hdmi_ary,
    output logic                         led
);

    player_in_t  [NUM_PLAYERS-1:0] raw;
    player_out_t [NUM_PLAYERS-1:0] mapped;
    logic                          game_pause;
    logic                          soft_rst;
    logic                          rot_control;

    board_reset #(.RST_CYCLES(RST_CYCLES)) u_reset (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .pll_locked  (pll_locked),
        .rst_req     (rst_req),
        .downloading (downloading),
        .soft_rst    (soft_rst),
        .dip_flip    (dip_flip),
        .sys_rst_n   (sys_rst_n),
        .game_rst_n  (game_rst_n)
    );

    input_merge u_merge (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .board_joy (board_joy),
        .key_joy   (key_joy),
        .key_start (key_start),
        .key_coin  (key_coin),
        .raw       (raw)
    );

    // One mapper per player slot
    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        player_map #(
            .BUTTONS    (BUTTONS),
            .ACTIVE_LOW (ACTIVE_LOW)
        ) u_map (
            .clk_sys     (clk_sys),
            .rst_n       (rst_n),
            .raw         (raw[p]),
            .rot_control (rot_control),
            .mapped      (mapped[p])
        );
    end

    input_collect #(.ACTIVE_LOW(ACTIVE_LOW)) u_collect (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .mapped       (mapped),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .osd_shown    (osd_shown),
        .game_joy     (game_joy),
        .game_start   (game_start),
        .game_coin    (game_coin),
        .game_service (game_service),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst)
    );

    dip_decode u_dip (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .status        (status),
        .core_vertical (core_mod[0]),
        .game_pause    (game_pause),
        .key_test      (key_test),
        .rotate        (rotate),
        .rot_control   (rot_control),
        .dip_flip      (dip_flip),
        .dip_test      (dip_test),
        .dip_pause     (dip_pause),
        .enable_fm     (enable_fm),
        .enable_psg    (enable_psg),
        .dip_fxlevel   (dip_fxlevel),
        .hdmi_arx      (hdmi_arx),
        .hdmi_ary      (hdmi_ary)
    );

    status_led #(.BLINK_HALF(BLINK_HALF)) u_led (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .downloading (downloading),
        .osd_shown   (osd_shown),
        .game_led    (game_led),
        .led         (led)
    );

endmodule

`default_nettype wire

/* test/board_tb.sv */
`default_nettype none

module board_tb
    import board_pkg::*;
();

    localparam int RST_CYCLES = 4;
    localparam int BLINK_HALF = 8;
    localparam int BUTTONS    = 2;
    // Far above the roughly 170 cycles of all tests
    localparam int TIMEOUT_CYCLES = 3000;

    logic                         clk_sys;
    logic                         rst_n;
    logic                         pll_locked;
    logic                         rst_req;
    logic                         downloading;
    board_joy_t [NUM_PLAYERS-1:0] board_joy;
    joy_t       [KEY_PLAYERS-1:0] key_joy;
    logic       [NUM_PLAYERS-1:0] key_start;
    logic       [NUM_PLAYERS-1:0] key_coin;
    logic                         key_pause;
    logic                         key_reset;
    logic                         key_test;
    logic                         key_service;
    settings_t                    status;
    logic       [6:0]             core_mod;
    logic                         osd_shown;
    logic       [1:0]             game_led;
    logic                         sys_rst_n;
    logic                         game_rst_n;
    joy_t       [NUM_PLAYERS-1:0] game_joy;
    logic       [NUM_PLAYERS-1:0] game_start;
    logic       [NUM_PLAYERS-1:0] game_coin;
    logic                         game_service;
    logic       [1:0]             rotate;
    logic                         dip_flip;
    logic                         dip_test;
    logic                         dip_pause;
    logic                         enable_fm;
    logic                         enable_psg;
    logic       [1:0]             dip_fxlevel;
    logic       [11:0]            hdmi_arx;
    logic       [11:0]            hdmi_ary;
    logic                         led;

    int errors;
    int tests;
    int cycle_cnt;
    int seed;

    board_top #(
        .BUTTONS    (BUTTONS),
        .ACTIVE_LOW (1),
        .RST_CYCLES (RST_CYCLES),
        .BLINK_HALF (BLINK_HALF)
    ) dut_i (.*);

    initial clk_sys = 1'b0;
    always #4 clk_sys = ~clk_sys;

    // Stops a stuck run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycle_cnt++;
        end
        $display("Timeout: the tests were still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic flag_error(string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    // Active high merge, remap, button mask, then game polarity
    function automatic logic [11:0] expected_word(board_joy_t b, joy_t k, logic ks, logic kc,
                                                  logic rot);
        joy_t a;
        joy_t r;
        a = ~b.joy | k;
        r = a;
        if (rot) begin
            r.up    = a.left;
            r.right = a.up;
            r.down  = a.right;
            r.left  = a.down;
        end
        for (int i = BUTTONS; i < 6; i++) begin
            r.buttons[i] = 1'b0;
        end
        return ~{~b.coin | kc, ~b.start | ks, r};
    endfunction

    task automatic check_player(int p, logic rot);
        joy_t        kj;
        logic [11:0] exp_w;
        logic [11:0] got_w;
        kj = '0;
        if (p < KEY_PLAYERS) begin
            kj = key_joy[p];
        end
        exp_w = expected_word(board_joy[p], kj, key_start[p], key_coin[p], rot);
        got_w = {game_coin[p], game_start[p], game_joy[p]};
        if (got_w !== exp_w) begin
            flag_error($sformatf("player %0d got %03h, expected %03h", p + 1, got_w, exp_w));
        end
    endtask

    task automatic count_game_release(int expected);
        int n;
        n = 0;
        while (!game_rst_n && n <= 4 * RST_CYCLES) begin
            wait_cycles(1);
            n++;
        end
        if (n != expected) begin
            flag_error($sformatf("game_rst_n released after %0d cycles, expected %0d",
                                 n, expected));
        end
    endtask

    // Counts from the cycle after the last reset cause
    task automatic check_release();
        int n;
        n = 0;
        while (!sys_rst_n && n <= 4 * RST_CYCLES) begin
            wait_cycles(1);
            n++;
        end
        if (n != RST_CYCLES) begin
            flag_error($sformatf("sys_rst_n released after %0d cycles, expected %0d",
                                 n, RST_CYCLES));
        end
        while (!game_rst_n && n <= 4 * RST_CYCLES) begin
            wait_cycles(1);
            n++;
        end
        if (n < RST_CYCLES || n > 2 * RST_CYCLES) begin
            flag_error($sformatf("game_rst_n released after %0d cycles", n));
        end
    endtask

    task automatic reset_sequence();
        tests++;
        if ({game_joy, game_start, game_coin, game_service} !== '1) begin
            flag_error("player outputs not inactive after reset");
        end
        if ({dip_test, dip_pause, led, sys_rst_n, game_rst_n} !== 5'b0) begin
            flag_error("switch, LED or reset outputs not low after reset");
        end
        check_release();
        pll_locked = 1'b0;
        wait_cycles(1);
        if (sys_rst_n !== 1'b0 || game_rst_n !== 1'b0) begin
            flag_error("resets not asserted after PLL lock loss");
        end
        wait_cycles(2);
        pll_locked = 1'b1;
        check_release();
        downloading = 1'b1;
        wait_cycles(1);
        if (sys_rst_n !== 1'b1 || game_rst_n !== 1'b0) begin
            flag_error("download did not hold only the game reset");
        end
        downloading = 1'b0;
        count_game_release(RST_CYCLES);
        key_reset = 1'b1;
        wait_cycles(1);
        key_reset = 1'b0;
        wait_cycles(1);
        if (game_rst_n !== 1'b0) begin
            flag_error("game_rst_n not low after key_reset");
        end
        count_game_release(RST_CYCLES);
    endtask

    task automatic joystick_mapping();
        tests++;
        key_service = 1'b1;
        for (int it = 0; it < 8; it++) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                board_joy[p] = 16'($random(seed));
            end
            for (int p = 0; p < KEY_PLAYERS; p++) begin
                // Sparse keyboard presses
                key_joy[p] = 10'($random(seed) & $random(seed));
            end
            key_start = 4'($random(seed) & $random(seed));
            key_coin  = 4'($random(seed) & $random(seed));
            wait_cycles(3);
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                check_player(p, 1'b0);
            end
        end
        if (game_service !== 1'b0) begin
            flag_error("game_service not active for a held service key");
        end
        key_service = 1'b0;
        key_joy     = '0;
        key_start   = '0;
        key_coin    = '0;
    endtask

    task automatic rotation();
        tests++;
        status.rotate = 2'b01;
        for (int vert = 1; vert >= 0; vert--) begin
            core_mod = 7'(vert);
            for (int d = 0; d < 4; d++) begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                    board_joy[p] = ~(16'd1 << d);
                end
                wait_cycles(5);
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                    check_player(p, 1'(vert));
                end
            end
        end
        board_joy = '1;
        status    = '0;
        core_mod  = '0;
    endtask

    task automatic check_settings(settings_t s, logic vert, logic ktest);
        logic        rot;
        logic [11:0] ex;
        logic [11:0] ey;
        status   = s;
        core_mod = {6'b0, vert};
        key_test = ktest;
        wait_cycles(1);
        rot = s.rotate[0] & vert;
        ex  = s.wide ? 12'd16 : 12'd4;
        ey  = s.wide ? 12'd9 : 12'd3;
        // Game pause is off here, so dip_pause is the field alone
        if ({rotate, dip_flip, dip_test, dip_pause, enable_fm, enable_psg, dip_fxlevel} !==
            {s.rotate, s.flip, s.test | ktest, s.pause, ~s.fm_off, ~s.psg_off, s.fxlevel}) begin
            flag_error($sformatf("switch outputs wrong for status %08h", s));
        end
        if ({hdmi_arx, hdmi_ary} !== ((vert && !rot) ? {ey, ex} : {ex, ey})) begin
            flag_error($sformatf("aspect %0d:%0d wrong for status %08h vertical %0b",
                                 hdmi_arx, hdmi_ary, s, vert));
        end
    endtask

    task automatic settings_decode();
        settings_t s;
        tests++;
        s = '0;
        check_settings(s, 1'b0, 1'b0);
        check_settings(s, 1'b0, 1'b1);
        s.flip = 1'b1;
        check_settings(s, 1'b0, 1'b0);
        s = '0;
        s.test = 1'b1;
        check_settings(s, 1'b0, 1'b0);
        s = '0;
        s.pause = 1'b1;
        check_settings(s, 1'b0, 1'b0);
        s = '0;
        s.fm_off = 1'b1;
        check_settings(s, 1'b0, 1'b0);
        s = '0;
        s.psg_off = 1'b1;
        s.fxlevel = 2'b10;
        check_settings(s, 1'b0, 1'b0);
        s = '0;
        s.rotate = 2'b11;
        check_settings(s, 1'b0, 1'b0);
        s = '0;
        check_settings(s, 1'b1, 1'b0);
        s.wide = 1'b1;
        check_settings(s, 1'b0, 1'b0);
        check_settings(s, 1'b1, 1'b0);
        s.rotate = 2'b01;
        check_settings(s, 1'b1, 1'b0);
        status   = '0;
        core_mod = '0;
        key_test = 1'b0;
        wait_cycles(RST_CYCLES + 2);
    endtask

    task automatic pause_and_led();
        int   toggles;
        logic prev;
        tests++;
        for (int press = 0; press < 2; press++) begin
            key_pause = 1'b1;
            wait_cycles(1);
            key_pause = 1'b0;
            wait_cycles(1);
            if (dip_pause !== (press == 0)) begin
                flag_error($sformatf("dip_pause is %0b after pause press %0d",
                                     dip_pause, press + 1));
            end
        end
        downloading = 1'b1;
        toggles     = 0;
        prev        = led;
        for (int i = 0; i < 40; i++) begin
            wait_cycles(1);
            if (led !== prev) begin
                toggles++;
            end
            prev = led;
        end
        if (toggles < 2) begin
            flag_error($sformatf("led toggled %0d times while downloading", toggles));
        end
        downloading = 1'b0;
        osd_shown   = 1'b1;
        wait_cycles(1);
        if (led !== 1'b1) begin
            flag_error("led not lit with the menu open");
        end
        osd_shown = 1'b0;
        game_led  = 2'b01;
        wait_cycles(1);
        if (led !== 1'b1) begin
            flag_error("led does not follow game_led bit 0 high");
        end
        game_led = 2'b10;
        wait_cycles(1);
        if (led !== 1'b0) begin
            flag_error("led does not follow game_led bit 0 low");
        end
    endtask

    initial begin
        seed        = 32'h64ae_df6d;
        errors      = 0;
        tests       = 0;
        rst_n       = 1'b0;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        board_joy   = '1;
        key_joy     = '0;
        key_start   = '0;
        key_coin    = '0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_test    = 1'b0;
        key_service = 1'b0;
        status      = '0;
        core_mod    = '0;
        osd_shown   = 1'b0;
        game_led    = 2'b00;
        wait_cycles(3);
        rst_n = 1'b1;
        reset_sequence();
        joystick_mapping();
        rotation();
        settings_decode();
        pause_and_led();
        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/board_pkg.sv
verilog/board_reset.sv
verilog/input_merge.sv
verilog/player_map.sv
verilog/input_collect.sv
verilog/dip_decode.sv
verilog/status_led.sv
verilog/board_top.sv
test/board_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -Wno-fatal --top-module board_tb -f files.f -o board_sim &&
./obj_dir/board_sim | tee /dev/stderr | grep "Regression passed" > /dev/null &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
